// File: sim.f
+incdir+sim
common/core_pkg.sv
hdl/core_alu.sv
hdl/core_regs.sv
hdl/core_ramctl.sv
hdl/core_pc.sv
ctrl/core_ctrl.sv
hdl/core_top.sv
sim/tb_clk.sv
sim/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the core testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_core -o tb_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim/tb_iss.svh
// reference instruction-set model

// runs the image in img from address 0 until HALT
function automatic void run_iss();
    logic [15:0] ir;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic        cy;
    logic [23:0] pc;
    logic [11:0] ea;
    logic        taken;
    bit          done;
    int          steps;
    iss_mem   = img;
    iss_regs  = '{default: '0};
    iss_flags = 3'b000;
    pc        = '0;
    done      = 0;
    for (steps = 0; steps < 10000 && !done; steps++) begin
        ir = {iss_mem[pc[11:0] + 12'd1], iss_mem[pc[11:0]]};
        pc = pc + 24'd2;
        a  = iss_regs[ir[10:8]];   // destination register
        b  = iss_regs[ir[2:0]];    // source register
        case (ir[15:12])
            4'h1: iss_regs[ir[10:8]] = {8'h00, ir[7:0]};
            4'h2: begin
                cy = 1'b0;
                case (ir[5:3])
                    3'd0: begin
                        r  = a + b;
                        cy = r < a;         // sum wrapped past ffff
                    end
                    3'd1: begin
                        r  = a - b;
                        cy = a < b;         // borrow
                    end
                    3'd2:    r = a & b;
                    3'd3:    r = a | b;
                    3'd4:    r = a ^ b;
                    default: r = '0;
                endcase
                iss_regs[ir[10:8]] = r;
                iss_flags = {r == 16'h0000, cy, r[15]};
            end
            4'h3: begin
                ea = {b[11:1], 1'b0};
                iss_regs[ir[10:8]] = {iss_mem[ea + 12'd1], iss_mem[ea]};
            end
            4'h4: begin
                ea = {a[11:1], 1'b0};
                iss_mem[ea]         = b[7:0];
                iss_mem[ea + 12'd1] = b[15:8];
            end
            4'h5: iss_mem[a[11:0]] = b[7:0];
            4'h6: begin
                case (ir[9:8])
                    2'd0:    taken = 1'b1;
                    2'd1:    taken = iss_flags[2];
                    2'd2:    taken = !iss_flags[2];
                    default: taken = 1'b0;
                endcase
                if (taken) pc = pc + {{15{ir[7]}}, ir[7:0], 1'b0};
            end
            4'hf: done = 1;
            default: ;     // no operation
        endcase
    end
    iss_pc = pc;
endfunction

// File: sim/tb_core.sv
// core testbench
// RAM model, programs and result checks

module tb_core;

    logic            clk, rst_n, test_rst_n, core_rst_n, cen, load_en;
    core_pkg::word_t ram_dout, ram_din;
    core_pkg::addr_t ram_addr;
    logic [1:0]      ram_we;
    logic [7:0]      dmp_addr, dmp_din;
    logic            halted;
    logic [11:0]     wa;

    logic [7:0]  ram [4096];
    logic [7:0]  img [4096];
    logic [7:0]  iss_mem [4096];
    logic [15:0] iss_regs [8];
    logic [2:0]  iss_flags;     // z, c, s
    logic [23:0] iss_pc;

    logic [15:0] prog_all [$];
    int          prog_start [5];
    int          errors, halt_errs, wd_limit, p;
    integer      seed;
    bit          halt_seen;

    `include "tb_iss.svh"

    tb_clk u_clk (.clk(clk), .rst_n(rst_n));

    assign core_rst_n = rst_n & test_rst_n;

    core_top uut (
        .clk(clk), .rst_n(core_rst_n), .cen(cen), .ram_dout(ram_dout), .dmp_addr(dmp_addr),
        .ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we), .dmp_din(dmp_din),
        .halted(halted)
    );

    // RAM model, one cycle read latency, byte lanes
    assign wa = {ram_addr[11:1], 1'b0};
    always @(posedge clk) begin
        if (load_en) begin
            ram <= img;
        end else if (cen) begin
            ram_dout <= {ram[wa + 12'd1], ram[wa]};
            if (ram_we[0]) ram[wa] <= ram_din[7:0];
            if (ram_we[1]) ram[wa + 12'd1] <= ram_din[15:8];
        end
    end

    initial seed = 32'h4d162e8e;
    always @(posedge clk) cen <= ($random(seed) & 3) != 0;   // about 75 percent

    // halted must never drop once up
    always @(negedge clk) begin
        if (!core_rst_n) begin
            halt_seen = 0;
        end else begin
            if (halt_seen) begin
                assert (halted) else begin
                    halt_errs++;
                    $display("halted dropped after the HALT instruction");
                end
            end
            if (halted) halt_seen = 1;
        end
    end

    function automatic logic [15:0] enc_ldi(input logic [2:0] d, input logic [7:0] v);
        return {4'h1, 1'b0, d, v};
    endfunction

    function automatic logic [15:0] enc_alu(input logic [2:0] op, input logic [2:0] d,
                                            input logic [2:0] s);
        return {4'h2, 1'b0, d, 2'b00, op, s};
    endfunction

    function automatic logic [15:0] enc_mem(input logic [3:0] op, input logic [2:0] d,
                                            input logic [2:0] s);
        return {op, 1'b0, d, 5'b00000, s};
    endfunction

    function automatic logic [15:0] enc_jr(input logic [1:0] c, input logic [7:0] disp);
        return {4'h6, 2'b00, c, disp};
    endfunction

    function automatic logic [7:0] expected_dump(input int i);
        if (i < 16) return i[0] ? iss_regs[i / 2][15:8] : iss_regs[i / 2][7:0];
        if (i == 16) return iss_pc[7:0];
        if (i == 17) return iss_pc[15:8];
        if (i == 18) return iss_pc[23:16];
        return {5'b00000, iss_flags};
    endfunction

    task automatic read_dump(input logic [7:0] a, output logic [7:0] v);
        @(posedge clk);
        dmp_addr <= a;
        @(negedge clk);
        v = dmp_din;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic run_test(input int n);
        logic [11:0] a;
        logic [7:0]  v;
        @(posedge clk);
        test_rst_n <= 1'b0;
        for (int i = 0; i < 4096; i++) begin
            a = i[11:0];
            img[a] = a[7:0] ^ {a[11:8], a[11:8]};
        end
        for (int i = prog_start[n]; i < prog_start[n + 1]; i++) begin
            a = 12'((i - prog_start[n]) * 2);
            img[a]         = prog_all[i][7:0];
            img[a + 12'd1] = prog_all[i][15:8];
        end
        @(posedge clk);
        load_en <= 1'b1;
        @(posedge clk);
        load_en <= 1'b0;
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_byte("ram_we", {6'd0, ram_we}, 8'h00);
        check_byte("halted", {7'd0, halted}, 8'h00);
        for (int i = 0; i < 20; i++) begin
            read_dump(i[7:0], v);
            check_byte($sformatf("reset dmp_din[%0d]", i), v, 8'h00);
        end
        run_iss();
        @(posedge clk);
        test_rst_n <= 1'b1;
        @(posedge clk);
        while (!halted) @(posedge clk);
        repeat (5) @(posedge clk);
        for (int i = 0; i < 20; i++) begin
            read_dump(i[7:0], v);
            check_byte($sformatf("prog %0d dmp_din[%0d]", n, i), v, expected_dump(i));
        end
        for (a = 12'h100; a < 12'h140; a++) begin
            check_byte($sformatf("prog %0d ram[%h]", n, a), ram[a], iss_mem[a]);
        end
    endtask

    initial begin
        test_rst_n = 1'b0;
        load_en    = 1'b0;
        dmp_addr   = 8'h00;
        cen        = 1'b0;
        ram_dout   = '0;
        errors     = 0;
        halt_errs  = 0;
        wd_limit   = 0;
        // ALU program, add overflow last
        prog_start[0] = 0;
        prog_all.push_back(enc_ldi(3'd4, 8'h3c));
        for (int k = 0; k < 3; k++) begin
            prog_all.push_back(enc_ldi(3'(5 + k), 8'ha5));
            prog_all.push_back(enc_alu(3'(2 + k), 3'(5 + k), 3'd4));  // and, or, xor
        end
        prog_all.push_back(enc_ldi(3'd0, 8'h00));
        prog_all.push_back(enc_ldi(3'd1, 8'h01));
        prog_all.push_back(enc_alu(3'd1, 3'd0, 3'd1));       // 0 - 1
        prog_all.push_back(enc_ldi(3'd2, 8'h01));
        prog_all.push_back(enc_alu(3'd0, 3'd0, 3'd2));       // ffff + 1
        prog_all.push_back(16'hf000);
        // word and byte stores, borrow last
        prog_start[1] = prog_all.size();
        prog_all.push_back(enc_ldi(3'd0, 8'h80));
        prog_all.push_back(enc_alu(3'd0, 3'd0, 3'd0));       // r0 = 0x100
        prog_all.push_back(enc_ldi(3'd1, 8'hff));
        prog_all.push_back(enc_alu(3'd0, 3'd1, 3'd1));
        prog_all.push_back(enc_mem(4'h4, 3'd0, 3'd1));
        prog_all.push_back(enc_mem(4'h3, 3'd2, 3'd0));
        prog_all.push_back(enc_ldi(3'd3, 8'h02));
        prog_all.push_back(enc_alu(3'd0, 3'd3, 3'd0));
        prog_all.push_back(enc_ldi(3'd4, 8'h5a));
        prog_all.push_back(enc_mem(4'h5, 3'd3, 3'd4));       // even byte
        prog_all.push_back(enc_ldi(3'd5, 8'h05));
        prog_all.push_back(enc_alu(3'd0, 3'd5, 3'd0));
        prog_all.push_back(enc_mem(4'h5, 3'd5, 3'd1));       // odd byte
        prog_all.push_back(enc_mem(4'h3, 3'd6, 3'd3));
        prog_all.push_back(enc_ldi(3'd7, 8'h01));
        prog_all.push_back(enc_alu(3'd1, 3'd7, 3'd4));
        prog_all.push_back(16'hf000);
        // forward conditional jumps
        prog_start[2] = prog_all.size();
        prog_all.push_back(enc_ldi(3'd0, 8'h01));
        prog_all.push_back(enc_ldi(3'd1, 8'h01));
        prog_all.push_back(enc_alu(3'd1, 3'd0, 3'd1));
        prog_all.push_back(enc_jr(2'd1, 8'h01));
        prog_all.push_back(enc_ldi(3'd2, 8'hee));            // skipped
        prog_all.push_back(enc_jr(2'd2, 8'h01));             // not taken
        prog_all.push_back(enc_ldi(3'd3, 8'h33));
        prog_all.push_back(enc_jr(2'd0, 8'h01));
        prog_all.push_back(enc_ldi(3'd4, 8'h44));            // skipped
        prog_all.push_back(16'hf000);
        // loop of five passes, backward jump
        prog_start[3] = prog_all.size();
        prog_all.push_back(enc_ldi(3'd0, 8'h05));
        prog_all.push_back(enc_ldi(3'd1, 8'h01));
        prog_all.push_back(enc_ldi(3'd3, 8'h03));
        prog_all.push_back(enc_alu(3'd0, 3'd2, 3'd3));
        prog_all.push_back(enc_alu(3'd1, 3'd0, 3'd1));
        prog_all.push_back(enc_jr(2'd2, 8'hfd));
        prog_all.push_back(enc_jr(2'd1, 8'h00));
        prog_all.push_back(16'hf000);
        prog_start[4] = prog_all.size();
        wd_limit = (prog_all.size() * 400 + 4 * 200) * 40;
        for (p = 0; p < 4; p++) run_test(p);
        $display("errors: %0d checks, %0d halted", errors, halt_errs);
        if (errors + halt_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("watchdog expired before all programs halted");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: sim/tb_clk.sv
// testbench clock and power-on reset

module tb_clk (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #20 clk = ~clk;      // period 40

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: hdl/core_top.sv
// register CPU core top

module core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  core_pkg::word_t     ram_dout,
    input  logic [7:0]          dmp_addr,
    output core_pkg::addr_t     ram_addr,
    output core_pkg::word_t     ram_din,
    output logic [1:0]          ram_we,
    output logic [7:0]          dmp_din,
    output logic                halted
);

    core_pkg::mem_req_t ctrl_req, ram_req;
    logic               ram_rdy;
    core_pkg::word_t    ram_rdata;

    core_pkg::reg_sel_t rd_a, rd_b, wr_sel;
    logic               wr_en, wr_data_sel;
    core_pkg::word_t    imm, wr_data;
    core_pkg::word_t    a_out, b_out, alu_result;
    core_pkg::alu_op_t  alu_op;
    logic               alu_we;
    core_pkg::flags_t   flags;

    logic               pc_inc, pc_jump;
    core_pkg::addr_t    pc, pc_disp;

    // data accesses take address and data from the register file
    always_comb begin
        ram_req = ctrl_req;
        if (ctrl_req.kind != core_pkg::MEM_NONE && ctrl_req.kind != core_pkg::MEM_FETCH) begin
            ram_req.addr  = {8'h00, a_out};
            ram_req.wdata = b_out;
        end
    end

    assign wr_data = wr_data_sel ? alu_result : imm;

    core_ctrl u_ctrl (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cen         ( cen         ),
        .pc          ( pc          ),
        .mem_rdy     ( ram_rdy     ),
        .mem_rdata   ( ram_rdata   ),
        .flags       ( flags       ),
        .mem_req     ( ctrl_req    ),
        .rd_a        ( rd_a        ),
        .rd_b        ( rd_b        ),
        .wr_en       ( wr_en       ),
        .wr_sel      ( wr_sel      ),
        .wr_data_sel ( wr_data_sel ),
        .imm         ( imm         ),
        .alu_op      ( alu_op      ),
        .alu_we      ( alu_we      ),
        .pc_inc      ( pc_inc      ),
        .pc_jump     ( pc_jump     ),
        .pc_disp     ( pc_disp     ),
        .halted      ( halted      )
    );

    core_regs u_regs (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .rd_a     ( rd_a     ),
        .rd_b     ( rd_b     ),
        .wr_en    ( wr_en    ),
        .wr_sel   ( wr_sel   ),
        .wr_data  ( wr_data  ),
        .pc       ( pc       ),
        .flags    ( flags    ),
        .dmp_addr ( dmp_addr ),
        .a_out    ( a_out    ),
        .b_out    ( b_out    ),
        .dmp_din  ( dmp_din  )
    );

    core_alu u_alu (
        .clk    ( clk        ),
        .rst_n  ( rst_n      ),
        .cen    ( cen        ),
        .a      ( a_out      ),     // destination operand
        .b      ( b_out      ),
        .op     ( alu_op     ),
        .we     ( alu_we     ),
        .result ( alu_result ),
        .flags  ( flags      )
    );

    core_ramctl u_ramctl (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .cen      ( cen       ),
        .req      ( ram_req   ),
        .ram_dout ( ram_dout  ),
        .rdy      ( ram_rdy   ),
        .rdata    ( ram_rdata ),
        .ram_addr ( ram_addr  ),
        .ram_din  ( ram_din   ),
        .ram_we   ( ram_we    )
    );

    core_pc u_pc (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .cen   ( cen     ),
        .inc   ( pc_inc  ),
        .jump  ( pc_jump ),
        .disp  ( pc_disp ),
        .pc    ( pc      )
    );

endmodule

// File: ctrl/core_ctrl.sv
// core sequencer
// fetch, decode and execute FSM

module core_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  core_pkg::addr_t     pc,
    input  logic                mem_rdy,
    input  core_pkg::word_t     mem_rdata,
    input  core_pkg::flags_t    flags,
    output core_pkg::mem_req_t  mem_req,
    output core_pkg::reg_sel_t  rd_a,
    output core_pkg::reg_sel_t  rd_b,
    output logic                wr_en,
    output core_pkg::reg_sel_t  wr_sel,
    output logic                wr_data_sel,
    output core_pkg::word_t     imm,
    output core_pkg::alu_op_t   alu_op,
    output logic                alu_we,
    output logic                pc_inc,
    output logic                pc_jump,
    output core_pkg::addr_t     pc_disp,
    output logic                halted
);

    core_pkg::ctrl_state_t state, state_nxt;
    core_pkg::word_t       ir;
    core_pkg::inst_t       inst;
    core_pkg::inst_t       dec;
    logic                  wait_ld;    // MEM_WAIT serves a load, else a fetch
    logic                  take_jr;

    // split the instruction word into fields
    always_comb begin
        dec.opcode = ir[15:12];
        dec.dst    = ir[10:8];
        dec.src    = ir[2:0];
        dec.alu_op = ir[5:3];
        dec.cond   = ir[9:8];
        dec.imm8   = ir[7:0];
    end

    always_comb begin
        case (inst.cond)
            core_pkg::COND_ALWAYS: take_jr = 1'b1;
            core_pkg::COND_Z:      take_jr = flags.z;
            core_pkg::COND_NZ:     take_jr = !flags.z;
            default:               take_jr = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            core_pkg::RESET_WAIT: state_nxt = core_pkg::FETCH;
            core_pkg::FETCH:      state_nxt = core_pkg::MEM_WAIT;
            core_pkg::MEM_WAIT: begin
                if (mem_rdy) state_nxt = wait_ld ? core_pkg::WRITEBACK : core_pkg::DECODE;
            end
            core_pkg::DECODE:     state_nxt = core_pkg::EXEC;
            core_pkg::EXEC: begin
                case (inst.opcode)
                    core_pkg::OP_LDW:  state_nxt = core_pkg::MEM_WAIT;
                    core_pkg::OP_HALT: state_nxt = core_pkg::HALTED;
                    default:           state_nxt = core_pkg::FETCH;
                endcase
            end
            core_pkg::WRITEBACK:  state_nxt = core_pkg::FETCH;
            core_pkg::HALTED:     state_nxt = core_pkg::HALTED;   // stays until reset
            default:              state_nxt = core_pkg::RESET_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= core_pkg::RESET_WAIT;
            wait_ld <= 1'b0;
        end else if (cen) begin
            state <= state_nxt;
            if (state == core_pkg::FETCH || state == core_pkg::EXEC) begin
                wait_ld <= state == core_pkg::EXEC;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (state == core_pkg::MEM_WAIT && mem_rdy && !wait_ld) ir <= mem_rdata;
            if (state == core_pkg::DECODE) inst <= dec;
        end
    end

    // strobes, qualified by cen in the blocks that take them
    always_comb begin
        mem_req     = '0;
        wr_en       = 1'b0;
        wr_data_sel = 1'b0;
        alu_we      = 1'b0;
        pc_inc      = 1'b0;
        pc_jump     = 1'b0;
        case (state)
            core_pkg::FETCH: begin
                mem_req.kind = core_pkg::MEM_FETCH;
                mem_req.addr = pc;
                pc_inc       = 1'b1;
            end
            core_pkg::EXEC: begin
                case (inst.opcode)
                    core_pkg::OP_LDI: wr_en = 1'b1;
                    core_pkg::OP_ALU: begin
                        wr_en       = 1'b1;
                        wr_data_sel = 1'b1;
                        alu_we      = 1'b1;
                    end
                    core_pkg::OP_LDW: mem_req.kind = core_pkg::MEM_LOAD;
                    core_pkg::OP_STW: mem_req.kind = core_pkg::MEM_STW;
                    core_pkg::OP_STB: mem_req.kind = core_pkg::MEM_STB;
                    core_pkg::OP_JR:  pc_jump = take_jr;
                    default: ;
                endcase
            end
            core_pkg::WRITEBACK: wr_en = 1'b1;    // load data through imm
            default: ;
        endcase
    end

    assign rd_a    = inst.opcode == core_pkg::OP_LDW ? inst.src : inst.dst;
    assign rd_b    = inst.src;
    assign wr_sel  = inst.dst;
    assign imm     = state == core_pkg::WRITEBACK ? mem_rdata : {8'h00, inst.imm8};
    assign alu_op  = inst.alu_op;
    assign pc_disp = {{16{inst.imm8[7]}}, inst.imm8};   // word count, pc doubles it
    assign halted  = state == core_pkg::HALTED;

    // the RAM port stays quiet while a read is in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        state == core_pkg::MEM_WAIT |-> mem_req.kind == core_pkg::MEM_NONE);

endmodule

// File: hdl/core_pc.sv
// program counter

module core_pc (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  logic             inc,
    input  logic             jump,
    input  core_pkg::addr_t  disp,
    output core_pkg::addr_t  pc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (cen) begin
            if (inc) begin
                pc <= pc + 24'd2;
            end else if (jump) begin
                pc <= pc + {disp[22:0], 1'b0}; // pc already points past the JR
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

endmodule

// File: hdl/core_ramctl.sv
// RAM port sequencer
// fetch, load and store over one port

module core_ramctl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  core_pkg::mem_req_t  req,
    input  core_pkg::word_t     ram_dout,
    output logic                rdy,
    output core_pkg::word_t     rdata,
    output core_pkg::addr_t     ram_addr,
    output core_pkg::word_t     ram_din,
    output logic [1:0]          ram_we
);

    core_pkg::addr_t addr_q;    // address of the pending read
    logic            rd_req;
    logic            rd_pend;   // RAM data shows up this cycle

    assign rd_req   = req.kind == core_pkg::MEM_FETCH || req.kind == core_pkg::MEM_LOAD;
    assign ram_addr = req.kind != core_pkg::MEM_NONE ? req.addr : addr_q;

    // byte lanes
    always_comb begin
        ram_din = req.wdata;
        ram_we  = 2'b00;
        case (req.kind)
            core_pkg::MEM_STW: ram_we = 2'b11;
            core_pkg::MEM_STB: begin
                ram_din = {req.wdata[7:0], req.wdata[7:0]};
                ram_we  = req.addr[0] ? 2'b10 : 2'b01;  // odd address is the high lane
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            rdy     <= 1'b0;
            addr_q  <= '0;
        end else if (cen) begin
            rd_pend <= rd_req;
            rdy     <= rd_pend;             // one cycle after the latch loads
            if (rd_req) addr_q <= req.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && rd_pend) rdata <= ram_dout;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rd_pend |-> ram_we == 2'b00);

endmodule

// File: hdl/core_regs.sv
// general register file
// with byte dump port

module core_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  core_pkg::reg_sel_t  rd_a,
    input  core_pkg::reg_sel_t  rd_b,
    input  logic                wr_en,
    input  core_pkg::reg_sel_t  wr_sel,
    input  core_pkg::word_t     wr_data,
    input  core_pkg::addr_t     pc,
    input  core_pkg::flags_t    flags,
    input  logic [7:0]          dmp_addr,
    output core_pkg::word_t     a_out,
    output core_pkg::word_t     b_out,
    output logic [7:0]          dmp_din
);

    core_pkg::word_t regs [8];
    core_pkg::word_t dmp_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (cen && wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign a_out = regs[rd_a];
    assign b_out = regs[rd_b];

    // dump map: regs, then pc low first, then flags
    always_comb begin
        dmp_word = regs[dmp_addr[3:1]];
        dmp_din  = 8'h00;
        if (dmp_addr < 8'd16) begin
            dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
        end else begin
            case (dmp_addr)
                8'd16:   dmp_din = pc[7:0];
                8'd17:   dmp_din = pc[15:8];
                8'd18:   dmp_din = pc[23:16];
                8'd19:   dmp_din = {5'd0, flags};
                default: dmp_din = 8'h00;
            endcase
        end
    end

    // write data comes from ALU, immediate or RAM latch
    assert property (@(posedge clk) disable iff (!rst_n)
        cen && wr_en |-> !$isunknown(wr_data));

endmodule

// File: hdl/core_alu.sv
// 16-bit ALU
// result is combinational, flags registered

module core_alu (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  core_pkg::word_t    a,
    input  core_pkg::word_t    b,
    input  core_pkg::alu_op_t  op,
    input  logic               we,
    output core_pkg::word_t    result,
    output core_pkg::flags_t   flags
);

    logic [16:0] ext;   // bit 16 is carry or borrow

    always_comb begin
        case (op)
            core_pkg::ALU_ADD: ext = {1'b0, a} + {1'b0, b};
            core_pkg::ALU_SUB: ext = {1'b0, a} - {1'b0, b};  // borrow lands in bit 16
            core_pkg::ALU_AND: ext = {1'b0, a & b};
            core_pkg::ALU_OR:  ext = {1'b0, a | b};
            core_pkg::ALU_XOR: ext = {1'b0, a ^ b};
            default:           ext = '0;
        endcase
    end

    assign result = ext[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (cen && we) begin
            flags.z <= ext[15:0] == 16'h0000;
            flags.c <= ext[16];
            flags.s <= ext[15];
        end
    end

endmodule

// File: common/core_pkg.sv
// core shared types
// widths, opcodes and decoded instruction

package core_pkg;

    typedef logic [15:0] word_t;        // data and instruction word
    typedef logic [23:0] addr_t;        // byte address
    typedef logic [ 2:0] reg_sel_t;
    typedef logic [ 3:0] opcode_t;      // ir[15:12]
    typedef logic [ 2:0] alu_op_t;      // ir[5:3]
    typedef logic [ 1:0] cond_t;        // ir[9:8] for JR
    typedef logic [ 2:0] mem_kind_t;

    // instruction classes, unlisted values run as no operation
    localparam opcode_t OP_LDI  = 4'h1;
    localparam opcode_t OP_ALU  = 4'h2;
    localparam opcode_t OP_LDW  = 4'h3;
    localparam opcode_t OP_STW  = 4'h4;
    localparam opcode_t OP_STB  = 4'h5;
    localparam opcode_t OP_JR   = 4'h6;
    localparam opcode_t OP_HALT = 4'hf;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    localparam cond_t COND_ALWAYS = 2'd0;
    localparam cond_t COND_Z      = 2'd1;
    localparam cond_t COND_NZ     = 2'd2;  // 3 never jumps

    localparam mem_kind_t MEM_NONE  = 3'd0;
    localparam mem_kind_t MEM_FETCH = 3'd1;
    localparam mem_kind_t MEM_LOAD  = 3'd2;
    localparam mem_kind_t MEM_STW   = 3'd3;
    localparam mem_kind_t MEM_STB   = 3'd4;

    typedef struct packed {
        logic z;    // bit 2
        logic c;
        logic s;    // bit 0
    } flags_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_sel_t dst;
        reg_sel_t src;
        alu_op_t  alu_op;
        cond_t    cond;
        logic [7:0] imm8;
    } inst_t;

    typedef enum logic [2:0] {
        RESET_WAIT,
        FETCH,
        DECODE,
        EXEC,
        MEM_WAIT,
        WRITEBACK,
        HALTED
    } ctrl_state_t;

    typedef struct packed {
        mem_kind_t kind;
        addr_t     addr;
        word_t     wdata;
    } mem_req_t;

endpackage
